//--- bench/rvseed_properties.sv
// concurrent assertions on halt, pc freeze and retirement outputs of the core
`include "rvseed_consts.svh"

module rvseed_properties (
    input logic                       clk,
    input logic                       rst_i,
    input logic [`XLEN-1:0]           pc_o,
    input logic                       retire_o,
    input logic                       wb_wen_o,
    input logic [`REG_ADDR_WIDTH-1:0] wb_waddr_o,
    input logic                       unknown_o,
    input logic                       halt_o
);

    // halt is sticky until reset
    a_halt_sticky: assert property (@(posedge clk) disable iff (rst_i) !$fell(halt_o))
        else $error("halt_o dropped without reset");

    // first halted edge still sees the last pc step
    a_pc_frozen: assert property (@(posedge clk) disable iff (rst_i)
        (halt_o && $past(halt_o)) |-> $stable(pc_o))
        else $error("pc_o moved while halted");

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst_i)
        wb_wen_o |-> (wb_waddr_o != '0))
        else $error("write enable on register x0");

    a_quiet_halted: assert property (@(posedge clk) disable iff (rst_i)
        halt_o |-> !(retire_o || wb_wen_o || unknown_o))
        else $error("retirement activity while halted");

endmodule

//--- bench/rvseed_tb.sv
// testbench with clock, reset, instruction rom, reference model and directed tests
`include "rvseed_consts.svh"

module rvseed_tb;

    localparam int          ROM_DEPTH = 256;
    localparam int          TIMEOUT   = 200;
    localparam logic [31:0] NOP       = 32'h0000_0013;  // addi x0, x0, 0

    typedef logic [`XLEN-1:0]           word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_t;

    // what the model executes for each program slot
    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_LUI, K_EBREAK, K_ILLEGAL
    } kind_e;

    logic        clk;
    logic        rst_i;
    logic [31:0] inst_i;
    word_t       pc_o;
    logic        retire_o;
    word_t       retire_pc_o;
    logic        wb_wen_o;
    reg_t        wb_waddr_o;
    word_t       wb_wdata_o;
    logic        unknown_o;
    logic        halt_o;

    logic [31:0] rom [ROM_DEPTH];
    kind_e       kind_a [ROM_DEPTH];
    reg_t        rd_a [ROM_DEPTH];
    reg_t        rs1_a [ROM_DEPTH];
    reg_t        rs2_a [ROM_DEPTH];
    logic [19:0] imm_a [ROM_DEPTH];
    word_t       model [`REG_COUNT];
    int          prog_len;
    int          value_errors;
    int          timeout_errors;

    rvseed_top u_rvseed_top (
        .clk         (clk),
        .rst_i       (rst_i),
        .inst_i      (inst_i),
        .pc_o        (pc_o),
        .retire_o    (retire_o),
        .retire_pc_o (retire_pc_o),
        .wb_wen_o    (wb_wen_o),
        .wb_waddr_o  (wb_waddr_o),
        .wb_wdata_o  (wb_wdata_o),
        .unknown_o   (unknown_o),
        .halt_o      (halt_o)
    );

    bind rvseed_top rvseed_properties u_rvseed_properties (
        .clk        (clk),
        .rst_i      (rst_i),
        .pc_o       (pc_o),
        .retire_o   (retire_o),
        .wb_wen_o   (wb_wen_o),
        .wb_waddr_o (wb_waddr_o),
        .unknown_o  (unknown_o),
        .halt_o     (halt_o)
    );

    always #50 clk = ~clk;

    // word for the current pc, nop outside the rom
    always @(negedge clk) begin
        if (pc_o < word_t'(ROM_DEPTH * 4)) begin
            inst_i <= rom[pc_o[9:2]];
        end else begin
            inst_i <= NOP;
        end
    end

    task automatic mismatch(input string name, input word_t exp, input word_t act);
        $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
        value_errors++;
    endtask

    task automatic new_program();
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = NOP;
        end
        prog_len = 0;
    endtask

    // encode one instruction and note what the model should do with it
    task automatic emit(input kind_e kind, input int rd, input int rs1, input int rs2,
                        input int imm);
        rvseed_pkg::inst_u w;
        w = '0;
        case (kind)
            K_ADDI, K_ANDI, K_ORI, K_XORI: begin
                w.i_fmt.opcode = `OPC_OP_IMM;
                w.i_fmt.rd     = reg_t'(rd);
                w.i_fmt.rs1    = reg_t'(rs1);
                w.i_fmt.imm12  = 12'(imm);
                w.i_fmt.funct3 = (kind == K_ADDI) ? 3'b000 : (kind == K_ANDI) ? 3'b111 :
                                 (kind == K_ORI) ? 3'b110 : 3'b100;
            end
            K_LUI: begin
                w.u_fmt.opcode = `OPC_LUI;
                w.u_fmt.rd     = reg_t'(rd);
                w.u_fmt.imm20  = 20'(imm);
            end
            K_EBREAK: begin
                w.i_fmt.opcode = `OPC_SYSTEM;
                w.i_fmt.imm12  = 12'd1;
            end
            K_ILLEGAL: begin
                w.i_fmt.opcode = 7'b0000011;  // load, not implemented
                w.i_fmt.rd     = reg_t'(rd);
            end
            default: begin
                w.r_fmt.opcode = `OPC_OP;
                w.r_fmt.rd     = reg_t'(rd);
                w.r_fmt.rs1    = reg_t'(rs1);
                w.r_fmt.rs2    = reg_t'(rs2);
                w.r_fmt.funct7 = (kind == K_SUB) ? 7'b0100000 : 7'b0000000;
                w.r_fmt.funct3 = (kind == K_SLT) ? 3'b010 : (kind == K_XOR) ? 3'b100 :
                                 (kind == K_OR) ? 3'b110 : (kind == K_AND) ? 3'b111 : 3'b000;
            end
        endcase
        rom[prog_len]    = w;
        kind_a[prog_len] = kind;
        rd_a[prog_len]   = reg_t'(rd);
        rs1_a[prog_len]  = reg_t'(rs1);
        rs2_a[prog_len]  = reg_t'(rs2);
        imm_a[prog_len]  = 20'(imm);
        prog_len++;
    endtask

    // give x1..x31 known values before anything reads them
    task automatic init_regs();
        for (int r = 1; r < `REG_COUNT; r++) begin
            emit(K_ADDI, r, 0, 0, int'($urandom_range(4095, 0)));
        end
    endtask

    task automatic do_reset();
        @(negedge clk);
        rst_i = 1'b1;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            if (pc_o !== '0) mismatch("pc_o", '0, pc_o);
            if (halt_o !== 1'b0) mismatch("halt_o", '0, word_t'(halt_o));
            if (retire_o !== 1'b0) mismatch("retire_o", '0, word_t'(retire_o));
        end
        rst_i = 1'b0;  // the cycle just starting is the first one out of reset
        for (int r = 0; r < `REG_COUNT; r++) begin
            model[r] = '0;
        end
    endtask

    task automatic wait_retire(output bit ok);
        int n;
        n = 0;
        @(negedge clk);
        while (retire_o !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = (retire_o === 1'b1);
    endtask

    // model step for program slot k, compared against the retiring outputs
    task automatic check_retire(input int k);
        word_t a;
        word_t b;
        word_t imm;
        word_t res;
        logic  writes;
        a      = model[rs1_a[k]];
        b      = model[rs2_a[k]];
        imm    = {{(`XLEN-12){imm_a[k][11]}}, imm_a[k][11:0]};
        writes = 1'b1;
        case (kind_a[k])
            K_ADD:   res = a + b;
            K_SUB:   res = a - b;
            K_AND:   res = a & b;
            K_OR:    res = a | b;
            K_XOR:   res = a ^ b;
            K_SLT:   res = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            K_ADDI:  res = a + imm;
            K_ANDI:  res = a & imm;
            K_ORI:   res = a | imm;
            K_XORI:  res = a ^ imm;
            K_LUI:   res = {{(`XLEN-32){imm_a[k][19]}}, imm_a[k], 12'b0};
            default: begin
                res    = '0;
                writes = 1'b0;  // ebreak and unknown opcodes
            end
        endcase
        writes = writes && (rd_a[k] != '0);
        if (retire_pc_o !== word_t'(4 * k)) mismatch("retire_pc_o", word_t'(4 * k), retire_pc_o);
        if (wb_wen_o !== writes) mismatch("wb_wen_o", word_t'(writes), word_t'(wb_wen_o));
        if (unknown_o !== (kind_a[k] == K_ILLEGAL)) begin
            mismatch("unknown_o", word_t'(kind_a[k] == K_ILLEGAL), word_t'(unknown_o));
        end
        if (writes && wb_waddr_o !== rd_a[k]) begin
            mismatch("wb_waddr_o", word_t'(rd_a[k]), word_t'(wb_waddr_o));
        end
        if (writes && wb_wdata_o !== res) mismatch("wb_wdata_o", res, wb_wdata_o);
        if (writes) begin
            model[rd_a[k]] = res;
        end
    endtask

    task automatic run_program(input int count);
        bit ok;
        for (int k = 0; k < count; k++) begin
            wait_retire(ok);
            if (!ok) begin
                $display("timeout at %0t: instruction %0d did not retire within %0d cycles",
                         $time, k, TIMEOUT);
                timeout_errors++;
                return;
            end
            check_retire(k);
        end
    endtask

    task automatic test_pc_sequence();
        new_program();
        do_reset();
        for (int step = 1; step <= 8; step++) begin
            @(negedge clk);
            if (pc_o !== word_t'(4 * step)) mismatch("pc_o", word_t'(4 * step), pc_o);
        end
    endtask

    task automatic test_itype();
        kind_e kind;
        new_program();
        init_regs();
        repeat (20) begin
            kind = kind_e'(int'(K_ADDI) + int'($urandom_range(3, 0)));
            emit(kind, int'($urandom_range(31, 0)), int'($urandom_range(31, 0)), 0,
                 int'($urandom_range(4095, 0)));
        end
        emit(K_LUI, 5, 0, 0, int'($urandom_range(32'hfffff, 0)));
        emit(K_LUI, 6, 0, 0, 'h80001);
        emit(K_ADDI, 7, 5, 0, 'h7ff);
        do_reset();
        run_program(prog_len);
    endtask

    // rs1 is the previous rd (bypass), rs2 the rd two back (register file)
    task automatic test_rtype_deps();
        int prev1;
        int prev2;
        int rd;
        new_program();
        init_regs();
        emit(K_LUI, 20, 0, 0, 'h80000);  // large negative
        emit(K_LUI, 21, 0, 0, 'h7ffff);
        prev2 = 20;
        prev1 = 21;
        for (int i = 0; i < 18; i++) begin
            rd = int'($urandom_range(19, 1));  // x20 and x21 kept for the signed compares
            emit(kind_e'(i % 6), rd, prev1, prev2, 0);
            prev2 = prev1;
            prev1 = rd;
        end
        emit(K_SLT, 22, 20, 21, 0);
        emit(K_SLT, 23, 21, 20, 0);
        do_reset();
        run_program(prog_len);
    endtask

    task automatic test_x0();
        new_program();
        init_regs();
        emit(K_ADDI, 0, 3, 0, 55);
        emit(K_ADD, 0, 1, 2, 0);
        emit(K_ADD, 7, 0, 0, 0);
        emit(K_ORI, 8, 0, 0, 'h5a5);
        emit(K_OR, 9, 0, 4, 0);
        emit(K_SUB, 10, 4, 0, 0);
        do_reset();
        run_program(prog_len);
    endtask

    task automatic test_ebreak();
        word_t held_pc;
        new_program();
        emit(K_ADDI, 1, 0, 0, 5);
        emit(K_ADDI, 2, 1, 0, 3);
        emit(K_EBREAK, 0, 0, 0, 0);
        emit(K_ADDI, 3, 0, 0, 1);  // must never retire
        emit(K_ADDI, 4, 0, 0, 2);
        do_reset();
        run_program(3);
        @(negedge clk);
        if (halt_o !== 1'b1) mismatch("halt_o", word_t'(1), word_t'(halt_o));
        if (retire_o !== 1'b0) mismatch("retire_o", '0, word_t'(retire_o));
        held_pc = word_t'(4 * 5);  // slot after ebreak and the two dropped ones
        repeat (20) begin
            @(negedge clk);
            if (retire_o !== 1'b0) mismatch("retire_o", '0, word_t'(retire_o));
            if (halt_o !== 1'b1) mismatch("halt_o", word_t'(1), word_t'(halt_o));
            if (pc_o !== held_pc) mismatch("pc_o", held_pc, pc_o);
        end
    endtask

    task automatic test_illegal();
        new_program();
        init_regs();
        emit(K_ILLEGAL, 10, 0, 0, 0);
        emit(K_ADD, 11, 10, 0, 0);  // x10 must still hold its old value
        emit(K_ORI, 12, 10, 0, 0);
        do_reset();
        run_program(prog_len);
    endtask

    initial begin
        void'($urandom(33722));
        clk            = 1'b0;
        rst_i          = 1'b1;
        inst_i         = NOP;
        prog_len       = 0;
        value_errors   = 0;
        timeout_errors = 0;
        test_pc_sequence();
        test_itype();
        test_rtype_deps();
        test_x0();
        test_ebreak();
        test_illegal();
        $display("error counts: %0d mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the rvseed testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f rvseed.f --top-module rvseed_tb \
    -o rvseed_sim > build.log 2>&1 \
    && ./obj_dir/rvseed_sim > sim.log 2>&1

grep -qx "Simulation PASSED" sim.log 2>/dev/null \
    && echo "rvseed: pass" \
    || { echo "rvseed: fail, see build.log and sim.log"; exit 1; }

//--- rvseed.f
+incdir+source
source/rvseed_pkg.sv
source/rvseed_if.sv
source/if_stage.sv
source/id_stage.sv
source/id_ex_regs.sv
source/ex_wb_stage.sv
source/rvseed_top.sv
bench/rvseed_properties.sv
bench/rvseed_tb.sv

//--- source/ex_wb_stage.sv
// alu, register file with bypassed reads, retirement and halt
`include "rvseed_consts.svh"

module ex_wb_stage (
    input  logic                       clk,
    input  logic                       rst_i,
    exec_if.sink                       ex,
    rf_if.owner                        rf,
    output logic                       halt_o,
    output logic                       retire_o,
    output logic [`XLEN-1:0]           retire_pc_o,
    output logic                       wb_wen_o,
    output logic [`REG_ADDR_WIDTH-1:0] wb_waddr_o,
    output logic [`XLEN-1:0]           wb_wdata_o,
    output logic                       unknown_o
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic [`XLEN-1:0] alu_res;
    logic             halted_q;
    logic             live;

    // zero for x0, else the value retiring now, else the stored one
    function automatic logic [`XLEN-1:0] rf_read(
        input logic [`REG_ADDR_WIDTH-1:0] addr,
        input logic [`XLEN-1:0]           stored,
        input logic                       wen,
        input logic [`REG_ADDR_WIDTH-1:0] waddr,
        input logic [`XLEN-1:0]           wdata
    );
        if (addr == '0) begin
            return '0;
        end else if (wen && addr == waddr) begin
            return wdata;
        end
        return stored;
    endfunction

    always_comb begin
        case (ex.alu_op)
            rvseed_pkg::ALU_ADD:    alu_res = ex.src1 + ex.src2;
            rvseed_pkg::ALU_SUB:    alu_res = ex.src1 - ex.src2;
            rvseed_pkg::ALU_AND:    alu_res = ex.src1 & ex.src2;
            rvseed_pkg::ALU_OR:     alu_res = ex.src1 | ex.src2;
            rvseed_pkg::ALU_XOR:    alu_res = ex.src1 ^ ex.src2;
            rvseed_pkg::ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}},
                                               $signed(ex.src1) < $signed(ex.src2)};
            rvseed_pkg::ALU_PASS_B: alu_res = ex.src2;
            default:                alu_res = '0;
        endcase
    end

    assign live = ex.valid && !halted_q;  // drops everything younger than ebreak

    assign retire_o    = live;
    assign retire_pc_o = ex.pc;
    assign wb_wen_o    = live && ex.reg_wen;
    assign wb_waddr_o  = ex.waddr;
    assign wb_wdata_o  = alu_res;
    assign unknown_o   = live && ex.illegal;
    assign halt_o      = halted_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            halted_q <= 1'b0;
        end else if (live && ex.ebreak) begin
            halted_q <= 1'b1;  // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (wb_wen_o) begin
            regs[wb_waddr_o] <= wb_wdata_o;
        end
    end

    assign rf.rdata1 = rf_read(rf.raddr1, regs[rf.raddr1], wb_wen_o, wb_waddr_o, wb_wdata_o);
    assign rf.rdata2 = rf_read(rf.raddr2, regs[rf.raddr2], wb_wen_o, wb_waddr_o, wb_wdata_o);

endmodule

//--- source/id_ex_regs.sv
// pipeline buffer between decode and execute
`include "rvseed_consts.svh"

module id_ex_regs (
    input  logic   clk,
    input  logic   rst_i,
    exec_if.sink   dec_in,
    exec_if.source ex_out
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_out.valid <= 1'b0;  // no stale bundle after reset
        end else begin
            ex_out.valid <= dec_in.valid;
        end
    end

    // payload follows valid, qualified downstream
    always_ff @(posedge clk) begin
        ex_out.pc      <= dec_in.pc;
        ex_out.alu_op  <= dec_in.alu_op;
        ex_out.src1    <= dec_in.src1;
        ex_out.src2    <= dec_in.src2;
        ex_out.reg_wen <= dec_in.reg_wen;
        ex_out.waddr   <= dec_in.waddr;
        ex_out.ebreak  <= dec_in.ebreak;
        ex_out.illegal <= dec_in.illegal;
    end

endmodule

//--- source/id_stage.sv
// decoder with immediate generation and operand selection
`include "rvseed_consts.svh"

module id_stage (
    input  logic             fetch_valid_i,
    input  logic [`XLEN-1:0] fetch_pc_i,
    input  logic [31:0]      fetch_inst_i,
    rf_if.reader             rf,
    exec_if.source           dec
);

    rvseed_pkg::inst_u inst;
    logic [`XLEN-1:0]  imm_i;
    logic [`XLEN-1:0]  imm_u;
    logic              wen_raw;

    assign inst = fetch_inst_i;

    // r and i formats share the rs1 slot
    assign rf.raddr1 = inst.r_fmt.rs1;
    assign rf.raddr2 = inst.r_fmt.rs2;

    assign imm_i = {{(`XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    assign imm_u = {{(`XLEN-32){inst.u_fmt.imm20[19]}}, inst.u_fmt.imm20, 12'b0};

    assign dec.valid = fetch_valid_i;
    assign dec.pc    = fetch_pc_i;
    assign dec.waddr = inst.i_fmt.rd;

    always_comb begin
        dec.alu_op  = rvseed_pkg::ALU_ADD;
        dec.src1    = rf.rdata1;
        dec.src2    = rf.rdata2;
        dec.ebreak  = 1'b0;
        dec.illegal = 1'b0;
        wen_raw     = 1'b0;
        case (inst.r_fmt.opcode)
            `OPC_OP: begin
                wen_raw = 1'b1;
                case (inst.r_fmt.funct3)
                    3'b000: begin
                        if (inst.r_fmt.funct7 == 7'b0100000) begin
                            dec.alu_op = rvseed_pkg::ALU_SUB;
                        end else begin
                            dec.illegal = (inst.r_fmt.funct7 != 7'b0000000);
                        end
                    end
                    3'b010:  dec.alu_op = rvseed_pkg::ALU_SLT;
                    3'b100:  dec.alu_op = rvseed_pkg::ALU_XOR;
                    3'b110:  dec.alu_op = rvseed_pkg::ALU_OR;
                    3'b111:  dec.alu_op = rvseed_pkg::ALU_AND;
                    default: dec.illegal = 1'b1;  // shifts, sltu
                endcase
                if (inst.r_fmt.funct3 != 3'b000 && inst.r_fmt.funct7 != 7'b0000000) begin
                    dec.illegal = 1'b1;
                end
            end
            `OPC_OP_IMM: begin
                wen_raw  = 1'b1;
                dec.src2 = imm_i;
                case (inst.i_fmt.funct3)
                    3'b000:  dec.alu_op = rvseed_pkg::ALU_ADD;
                    3'b100:  dec.alu_op = rvseed_pkg::ALU_XOR;
                    3'b110:  dec.alu_op = rvseed_pkg::ALU_OR;
                    3'b111:  dec.alu_op = rvseed_pkg::ALU_AND;
                    default: dec.illegal = 1'b1;
                endcase
            end
            `OPC_LUI: begin
                wen_raw    = 1'b1;
                dec.alu_op = rvseed_pkg::ALU_PASS_B;
                dec.src1   = '0;  // rs1 slot holds immediate bits
                dec.src2   = imm_u;
            end
            `OPC_SYSTEM: begin
                dec.ebreak  = (fetch_inst_i == `INST_EBREAK);
                dec.illegal = (fetch_inst_i != `INST_EBREAK);  // ecall, csr
            end
            default: dec.illegal = 1'b1;
        endcase
    end

    assign dec.reg_wen = wen_raw && !dec.illegal && (inst.i_fmt.rd != '0);

endmodule

//--- source/if_stage.sv
// fetch stage with program counter, fetch latch and halt freeze
`include "rvseed_consts.svh"

module if_stage (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             halt_i,
    input  logic [31:0]      inst_i,
    output logic [`XLEN-1:0] pc_o,
    output logic             fetch_valid_o,
    output logic [`XLEN-1:0] fetch_pc_o,
    output logic [31:0]      fetch_inst_o
);

    localparam logic [`XLEN-1:0] PC_STEP = 4;

    logic [`XLEN-1:0] pc_q;

    assign pc_o = pc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= '0;
        end else if (!halt_i) begin
            pc_q <= pc_q + PC_STEP;  // no branches, always sequential
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= !halt_i;  // nothing new enters once stopped
        end
    end

    // word arrives in the same cycle as its pc
    always_ff @(posedge clk) begin
        fetch_pc_o   <= pc_q;
        fetch_inst_o <= inst_i;
    end

endmodule

//--- source/rvseed_consts.svh
// data width, register file geometry and major opcodes of the rv64 core
`ifndef RVSEED_CONSTS_SVH
`define RVSEED_CONSTS_SVH

// datapath and pc width
`define XLEN 64

// register file geometry
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// major opcodes, bits [6:0] of the word
`define OPC_OP     7'b0110011  // register-register alu
`define OPC_OP_IMM 7'b0010011  // register-immediate alu
`define OPC_LUI    7'b0110111  // load upper immediate
`define OPC_SYSTEM 7'b1110011  // ebreak lives here

// full encoding of ebreak
`define INST_EBREAK 32'h0010_0073

`endif

//--- source/rvseed_if.sv
// exec_if decoded bundle and rf_if register read port interfaces
`include "rvseed_consts.svh"

interface exec_if;
    logic                        valid;
    logic [`XLEN-1:0]            pc;
    rvseed_pkg::alu_op_e         alu_op;
    logic [`XLEN-1:0]            src1;
    logic [`XLEN-1:0]            src2;
    logic                        reg_wen;   // already cleared for x0
    logic [`REG_ADDR_WIDTH-1:0]  waddr;
    logic                        ebreak;
    logic                        illegal;   // unknown opcode, retires without write

    modport source (output valid, pc, alu_op, src1, src2, reg_wen, waddr, ebreak, illegal);
    modport sink   (input  valid, pc, alu_op, src1, src2, reg_wen, waddr, ebreak, illegal);
endinterface

interface rf_if;
    logic [`REG_ADDR_WIDTH-1:0] raddr1;
    logic [`REG_ADDR_WIDTH-1:0] raddr2;
    logic [`XLEN-1:0]           rdata1;  // bypassed in the owner
    logic [`XLEN-1:0]           rdata2;

    modport reader (output raddr1, raddr2, input  rdata1, rdata2);
    modport owner  (input  raddr1, raddr2, output rdata1, rdata2);
endinterface

//--- source/rvseed_pkg.sv
// alu operation enum and the instruction format union
`include "rvseed_consts.svh"

package rvseed_pkg;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,  // signed compare
        ALU_PASS_B = 3'd6   // lui, result is src2
    } alu_op_e;

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                imm12;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]                imm20;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } u_fmt_t;

    // one 32-bit word, three views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } inst_u;

endpackage

//--- source/rvseed_top.sv
// top level of the three part rv64 pipeline
`include "rvseed_consts.svh"

module rvseed_top (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [31:0]                inst_i,
    output logic [`XLEN-1:0]           pc_o,
    output logic                       retire_o,
    output logic [`XLEN-1:0]           retire_pc_o,
    output logic                       wb_wen_o,
    output logic [`REG_ADDR_WIDTH-1:0] wb_waddr_o,
    output logic [`XLEN-1:0]           wb_wdata_o,
    output logic                       unknown_o,
    output logic                       halt_o
);

    logic             fetch_valid;
    logic [`XLEN-1:0] fetch_pc;
    logic [31:0]      fetch_inst;

    exec_if dec_bus ();  // decode to buffer
    exec_if ex_bus ();   // buffer to execute
    rf_if   rf_bus ();

    if_stage u_if_stage (
        .clk           (clk),
        .rst_i         (rst_i),
        .halt_i        (halt_o),
        .inst_i        (inst_i),
        .pc_o          (pc_o),
        .fetch_valid_o (fetch_valid),
        .fetch_pc_o    (fetch_pc),
        .fetch_inst_o  (fetch_inst)
    );

    id_stage u_id_stage (
        .fetch_valid_i (fetch_valid),
        .fetch_pc_i    (fetch_pc),
        .fetch_inst_i  (fetch_inst),
        .rf            (rf_bus.reader),
        .dec           (dec_bus.source)
    );

    id_ex_regs u_id_ex_regs (
        .clk    (clk),
        .rst_i  (rst_i),
        .dec_in (dec_bus.sink),
        .ex_out (ex_bus.source)
    );

    ex_wb_stage u_ex_wb_stage (
        .clk         (clk),
        .rst_i       (rst_i),
        .ex          (ex_bus.sink),
        .rf          (rf_bus.owner),
        .halt_o      (halt_o),
        .retire_o    (retire_o),
        .retire_pc_o (retire_pc_o),
        .wb_wen_o    (wb_wen_o),
        .wb_waddr_o  (wb_waddr_o),
        .wb_wdata_o  (wb_wdata_o),
        .unknown_o   (unknown_o)
    );

endmodule
